// File: Makefile
TOP := mcu_ao_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "All checks passed"

clean:
	rm -rf obj_dir

// File: design/ao_ctrl_regs.sv
/*
  always-on control registers: exit value and valid for the host, the
  cpu power-off request and a read-back of the power sequencer state
*/
`timescale 1ns/100ps

module ao_ctrl_regs (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  mcu_ao_pkg::reg_req_t   req_i,
  output mcu_ao_pkg::reg_rsp_t   rsp_o,
  input  mcu_ao_pkg::pwr_state_e pwr_state_i,
  output logic                   pwr_off_req_o,
  output logic                   exit_valid_o,
  output mcu_ao_pkg::data_t      exit_value_o
);
  import mcu_ao_pkg::*;

  addr_t ofs;
  logic  wr_en;

  assign ofs   = req_i.addr & SLV_OFS_MASK;
  assign wr_en = req_i.valid && req_i.write;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exit_value_o  <= '0;
      exit_valid_o  <= 1'b0;
      pwr_off_req_o <= 1'b0;
    end else if (wr_en) begin
      case (ofs)
        EXIT_VALUE_OFS: exit_value_o  <= req_i.wdata;
        EXIT_VALID_OFS: exit_valid_o  <= req_i.wdata[0];
        PWR_CTRL_OFS:   pwr_off_req_o <= req_i.wdata[0];
        default: ;
      endcase
    end
  end

  // status is read only, writes to it are dropped
  always_comb begin
    rsp_o.ready = req_i.valid;
    rsp_o.error = 1'b0;
    case (ofs)
      EXIT_VALUE_OFS: rsp_o.rdata = exit_value_o;
      EXIT_VALID_OFS: rsp_o.rdata = data_t'(exit_valid_o);
      PWR_CTRL_OFS:   rsp_o.rdata = data_t'(pwr_off_req_o);
      PWR_STATUS_OFS: rsp_o.rdata = data_t'(pwr_state_i);
      default:        rsp_o.rdata = '0;
    endcase
  end

endmodule

// File: design/compare_timer.sv
/*
  compare timer; a free-running counter that raises a level interrupt
  while enabled and at or past the compare value
*/
`timescale 1ns/100ps

module compare_timer (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  mcu_ao_pkg::reg_req_t req_i,
  output mcu_ao_pkg::reg_rsp_t rsp_o,
  output logic                 irq_o
);
  import mcu_ao_pkg::*;

  addr_t ofs;
  logic  wr_en;
  logic  en_q;
  data_t count_q;
  data_t cmp_q;

  assign ofs   = req_i.addr & SLV_OFS_MASK;
  assign wr_en = req_i.valid && req_i.write;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      en_q    <= 1'b0;
      count_q <= '0;
      cmp_q   <= '0;
    end else begin
      if (en_q) begin
        count_q <= count_q + 32'd1;
      end
      // a host write to the counter overrides the increment
      if (wr_en) begin
        case (ofs)
          TIMER_CTRL_OFS:  en_q    <= req_i.wdata[0];
          TIMER_COUNT_OFS: count_q <= req_i.wdata;
          TIMER_CMP_OFS:   cmp_q   <= req_i.wdata;
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    rsp_o.ready = req_i.valid;
    rsp_o.error = 1'b0;
    case (ofs)
      TIMER_CTRL_OFS:  rsp_o.rdata = data_t'(en_q);
      TIMER_COUNT_OFS: rsp_o.rdata = count_q;
      TIMER_CMP_OFS:   rsp_o.rdata = cmp_q;
      default:         rsp_o.rdata = '0;
    endcase
  end

  assign irq_o = en_q && (count_q >= cmp_q);

endmodule

// File: design/cpu_power_gate_fsm.sv
/*
  power-gate sequencer of the cpu domain; isolates, resets and switches
  off on request, and reverses the order when the request is cleared
*/
`timescale 1ns/100ps

module cpu_power_gate_fsm (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   pwr_off_req_i,
  input  logic                   switch_ack_i,
  output logic                   switch_o,
  output logic                   iso_o,
  output logic                   rst_no,
  output mcu_ao_pkg::pwr_state_e state_o
);
  import mcu_ao_pkg::*;

  pwr_state_e state_q;
  pwr_state_e state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      PWR_ON:         if (pwr_off_req_i) state_d = PWR_ISO;
      PWR_ISO:        state_d = PWR_RST;
      PWR_RST:        state_d = PWR_SWITCH_OFF;
      // switch latency is set by the power switch itself
      PWR_SWITCH_OFF: if (switch_ack_i) state_d = PWR_OFF;
      PWR_OFF:        if (!pwr_off_req_i) state_d = PWR_SWITCH_ON;
      PWR_SWITCH_ON:  if (!switch_ack_i) state_d = PWR_UNISO;
      PWR_UNISO:      state_d = PWR_ON;
      default:        state_d = PWR_ON;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= PWR_ON;
    end else begin
      state_q <= state_d;
    end
  end

  // reset is released one cycle before isolation drops
  assign iso_o    = (state_q != PWR_ON);
  assign rst_no   = (state_q == PWR_ON) || (state_q == PWR_ISO) || (state_q == PWR_UNISO);
  assign switch_o = (state_q == PWR_SWITCH_OFF) || (state_q == PWR_OFF);
  assign state_o  = state_q;

endmodule

// File: design/gpio_ctrl.sv
/*
  gpio block with output and enable registers, a two-flop input
  synchronizer and rising-edge interrupts with write-one-to-clear status
*/
`timescale 1ns/100ps

module gpio_ctrl #(
  parameter int NUM_GPIO = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  mcu_ao_pkg::reg_req_t req_i,
  output mcu_ao_pkg::reg_rsp_t rsp_o,
  input  logic [NUM_GPIO-1:0]  gpio_i,
  output logic [NUM_GPIO-1:0]  gpio_o,
  output logic [NUM_GPIO-1:0]  gpio_oe_o,
  output logic [NUM_GPIO-1:0]  irq_o
);
  import mcu_ao_pkg::*;

  typedef logic [NUM_GPIO-1:0] pins_t;

  addr_t ofs;
  logic  wr_en;
  pins_t sync_meta_q;
  pins_t sync_q;
  pins_t prev_q;
  pins_t intr_en_q;
  pins_t status_q;
  pins_t rise;
  pins_t clr;

  assign ofs   = req_i.addr & SLV_OFS_MASK;
  assign wr_en = req_i.valid && req_i.write;

  assign rise = sync_q & ~prev_q & intr_en_q;
  assign clr  = (wr_en && ofs == GPIO_INTR_STATUS_OFS) ? req_i.wdata[NUM_GPIO-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync_meta_q <= '0;
      sync_q      <= '0;
      prev_q      <= '0;
      status_q    <= '0;
    end else begin
      sync_meta_q <= gpio_i;
      sync_q      <= sync_meta_q;
      prev_q      <= sync_q;
      // a new edge wins over a clear in the same cycle
      status_q    <= (status_q & ~clr) | rise;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      gpio_o    <= '0;
      gpio_oe_o <= '0;
      intr_en_q <= '0;
    end else if (wr_en) begin
      case (ofs)
        GPIO_OUT_OFS:     gpio_o    <= req_i.wdata[NUM_GPIO-1:0];
        GPIO_OE_OFS:      gpio_oe_o <= req_i.wdata[NUM_GPIO-1:0];
        GPIO_INTR_EN_OFS: intr_en_q <= req_i.wdata[NUM_GPIO-1:0];
        default: ;
      endcase
    end
  end

  always_comb begin
    rsp_o.ready = req_i.valid;
    rsp_o.error = 1'b0;
    case (ofs)
      GPIO_OUT_OFS:         rsp_o.rdata = data_t'(gpio_o);
      GPIO_OE_OFS:          rsp_o.rdata = data_t'(gpio_oe_o);
      GPIO_IN_OFS:          rsp_o.rdata = data_t'(sync_q);
      GPIO_INTR_EN_OFS:     rsp_o.rdata = data_t'(intr_en_q);
      GPIO_INTR_STATUS_OFS: rsp_o.rdata = data_t'(status_q);
      default:              rsp_o.rdata = '0;
    endcase
  end

  assign irq_o = status_q;

endmodule

// File: design/mcu_ao_pkg.sv
/*
  shared types, address map and register offsets of the always-on block,
  imported by the design and the testbench
*/
package mcu_ao_pkg;

  typedef logic [31:0] data_t;
  typedef logic [31:0] addr_t;
  typedef logic [31:0] irq_vec_t;

  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    data_t wdata;
  } reg_req_t;

  typedef struct packed {
    logic  ready;
    logic  error;
    data_t rdata;
  } reg_rsp_t;

  // slave windows, 4 KiB each, selected by addr[13:12]
  localparam int    NUM_SLV      = 3;
  localparam int    SLV_AO       = 0;
  localparam int    SLV_GPIO     = 1;
  localparam int    SLV_TIMER    = 2;
  localparam addr_t AO_CTRL_BASE = 32'h0000_0000;
  localparam addr_t GPIO_BASE    = 32'h0000_1000;
  localparam addr_t TIMER_BASE   = 32'h0000_2000;
  localparam addr_t SLV_OFS_MASK = 32'h0000_0fff;

  localparam addr_t EXIT_VALUE_OFS       = 32'h0;
  localparam addr_t EXIT_VALID_OFS       = 32'h4;
  localparam addr_t PWR_CTRL_OFS         = 32'h8;
  localparam addr_t PWR_STATUS_OFS       = 32'hc;
  localparam addr_t GPIO_OUT_OFS         = 32'h0;
  localparam addr_t GPIO_OE_OFS          = 32'h4;
  localparam addr_t GPIO_IN_OFS          = 32'h8;
  localparam addr_t GPIO_INTR_EN_OFS     = 32'hc;
  localparam addr_t GPIO_INTR_STATUS_OFS = 32'h10;
  localparam addr_t TIMER_CTRL_OFS       = 32'h0;
  localparam addr_t TIMER_COUNT_OFS      = 32'h4;
  localparam addr_t TIMER_CMP_OFS        = 32'h8;

  localparam int IRQ_TIMER_BIT = 7;
  localparam int IRQ_FAST_BASE = 16;

  typedef enum logic [2:0] {
    PWR_ON,
    PWR_ISO,
    PWR_RST,
    PWR_SWITCH_OFF,
    PWR_OFF,
    PWR_SWITCH_ON,
    PWR_UNISO
  } pwr_state_e;

endpackage

// File: design/mcu_ao_top.sv
/*
  always-on peripheral top: host register bus, power control of the cpu
  domain, gpio and compare timer, with the interrupt vector built here
*/
`timescale 1ns/100ps

module mcu_ao_top #(
  parameter int NUM_GPIO = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  mcu_ao_pkg::reg_req_t bus_req_i,
  output mcu_ao_pkg::reg_rsp_t bus_rsp_o,
  input  logic [NUM_GPIO-1:0]  gpio_i,
  output logic [NUM_GPIO-1:0]  gpio_o,
  output logic [NUM_GPIO-1:0]  gpio_oe_o,
  output logic                 exit_valid_o,
  output mcu_ao_pkg::data_t    exit_value_o,
  output logic                 cpu_powergate_switch_o,
  input  logic                 cpu_powergate_switch_ack_i,
  output logic                 cpu_powergate_iso_o,
  output logic                 cpu_rst_no,
  output mcu_ao_pkg::irq_vec_t irq_o
);
  import mcu_ao_pkg::*;

  reg_req_t [NUM_SLV-1:0] slv_req;
  reg_rsp_t [NUM_SLV-1:0] slv_rsp;
  logic                   pwr_off_req;
  pwr_state_e             pwr_state;
  logic                   timer_irq;
  logic [NUM_GPIO-1:0]    gpio_irq;

  // timer on bit 7, gpio on the fast lines
  always_comb begin
    irq_o = '0;
    irq_o[IRQ_TIMER_BIT] = timer_irq;
    irq_o[IRQ_FAST_BASE +: NUM_GPIO] = gpio_irq;
  end

  periph_bus_demux periph_bus_demux_i (
    .bus_req_i,
    .bus_rsp_o,
    .slv_req_o(slv_req),
    .slv_rsp_i(slv_rsp)
  );

  ao_ctrl_regs ao_ctrl_regs_i (
    .clk_i,
    .rst_i,
    .req_i(slv_req[SLV_AO]),
    .rsp_o(slv_rsp[SLV_AO]),
    .pwr_state_i(pwr_state),
    .pwr_off_req_o(pwr_off_req),
    .exit_valid_o,
    .exit_value_o
  );

  cpu_power_gate_fsm cpu_power_gate_fsm_i (
    .clk_i,
    .rst_i,
    .pwr_off_req_i(pwr_off_req),
    .switch_ack_i(cpu_powergate_switch_ack_i),
    .switch_o(cpu_powergate_switch_o),
    .iso_o(cpu_powergate_iso_o),
    .rst_no(cpu_rst_no),
    .state_o(pwr_state)
  );

  gpio_ctrl #(
    .NUM_GPIO(NUM_GPIO)
  ) gpio_ctrl_i (
    .clk_i,
    .rst_i,
    .req_i(slv_req[SLV_GPIO]),
    .rsp_o(slv_rsp[SLV_GPIO]),
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .irq_o(gpio_irq)
  );

  compare_timer compare_timer_i (
    .clk_i,
    .rst_i,
    .req_i(slv_req[SLV_TIMER]),
    .rsp_o(slv_rsp[SLV_TIMER]),
    .irq_o(timer_irq)
  );

endmodule

// File: design/periph_bus_demux.sv
/*
  routes a host request to one of the peripheral slaves by addr[13:12];
  the unmapped window answers with an error
*/
`timescale 1ns/100ps

module periph_bus_demux (
  input  mcu_ao_pkg::reg_req_t                     bus_req_i,
  output mcu_ao_pkg::reg_rsp_t                     bus_rsp_o,
  output mcu_ao_pkg::reg_req_t [mcu_ao_pkg::NUM_SLV-1:0] slv_req_o,
  input  mcu_ao_pkg::reg_rsp_t [mcu_ao_pkg::NUM_SLV-1:0] slv_rsp_i
);
  import mcu_ao_pkg::*;

  logic [1:0]         sel;
  logic [NUM_SLV-1:0] hit;

  // window selector of each slave index
  function automatic logic [1:0] slv_sel(input int idx);
    case (idx)
      SLV_AO:   return AO_CTRL_BASE[13:12];
      SLV_GPIO: return GPIO_BASE[13:12];
      default:  return TIMER_BASE[13:12];
    endcase
  endfunction

  assign sel = bus_req_i.addr[13:12];

  always_comb begin
    for (int i = 0; i < NUM_SLV; i++) begin
      hit[i]             = (sel == slv_sel(i));
      slv_req_o[i]       = bus_req_i;
      slv_req_o[i].valid = bus_req_i.valid && hit[i];
    end
  end

  always_comb begin
    // default is the error answer for selector 3
    bus_rsp_o.ready = bus_req_i.valid;
    bus_rsp_o.error = 1'b1;
    bus_rsp_o.rdata = '0;
    for (int i = 0; i < NUM_SLV; i++) begin
      if (hit[i]) begin
        bus_rsp_o = slv_rsp_i[i];
      end
    end
  end

endmodule

// File: dv/mcu_ao_properties.sv
/*
  concurrent checks on the bus response and the cpu power sequence,
  bound into the top level by the testbench
*/
`timescale 1ns/100ps

module mcu_ao_properties (
  input logic                 clk_i,
  input logic                 rst_i,
  input mcu_ao_pkg::reg_req_t bus_req_i,
  input mcu_ao_pkg::reg_rsp_t bus_rsp_i,
  input logic                 switch_i,
  input logic                 iso_i,
  input logic                 cpu_rst_ni
);

  // sticky once any assertion fails
  logic fail_seen = 1'b0;

  // no back-pressure on this bus
  a_ready_follows_valid: assert property (
    @(posedge clk_i) disable iff (rst_i) bus_rsp_i.ready == bus_req_i.valid
  ) else begin
    fail_seen = 1'b1;
    $error("bus ready does not follow valid");
  end

  a_iso_covers_gate: assert property (
    @(posedge clk_i) disable iff (rst_i) (!cpu_rst_ni || switch_i) |-> iso_i
  ) else begin
    fail_seen = 1'b1;
    $error("cpu domain reset or switched off without isolation");
  end

  // isolation must already be up before the switch opens
  a_switch_after_iso: assert property (
    @(posedge clk_i) disable iff (rst_i) $rose(switch_i) |-> $past(iso_i)
  ) else begin
    fail_seen = 1'b1;
    $error("power switch rose while isolation was low");
  end

endmodule

// File: dv/mcu_ao_tb.sv
/*
  table-driven testbench of the always-on top; applies the steps in order,
  checks bus reads and pins, and models the power switch acknowledge
*/
`timescale 1ns/100ps

module mcu_ao_tb;
  import mcu_ao_pkg::*;

  localparam int NUM_GPIO = 8;

  typedef enum logic [2:0] {
    OP_WR,
    OP_RD,
    OP_PINS,
    OP_WAIT,
    OP_OUT,
    OP_ACK
  } op_e;

  typedef struct packed {
    op_e   op;
    addr_t addr;
    data_t data;
    data_t exp;
  } step_t;

  // output selectors, used as addr of OP_OUT
  localparam int OUT_EXIT_VALUE = 0;
  localparam int OUT_EXIT_VALID = 1;
  localparam int OUT_GPIO       = 2;
  localparam int OUT_GPIO_OE    = 3;
  localparam int OUT_IRQ        = 4;
  localparam int OUT_PWR        = 5;

  logic                clk_i = 1'b0;
  logic                rst_i = 1'b1;
  reg_req_t            bus_req = '0;
  reg_rsp_t            bus_rsp;
  logic [NUM_GPIO-1:0] gpio_in = '0;
  logic [NUM_GPIO-1:0] gpio_out;
  logic [NUM_GPIO-1:0] gpio_oe;
  logic                exit_valid;
  data_t               exit_value;
  logic                switch_out;
  logic                switch_ack = 1'b0;
  logic                iso_out;
  logic                cpu_rst_n;
  irq_vec_t            irq;
  step_t               steps[$];
  int unsigned         ack_delay;
  data_t               out_val [6];
  string               out_names [6] = '{"exit_value_o", "exit_valid_o", "gpio_o",
                                         "gpio_oe_o", "irq_o", "{switch,iso,rst_n}"};

  mcu_ao_top #(
    .NUM_GPIO(NUM_GPIO)
  ) u_dut (
    .clk_i,
    .rst_i,
    .bus_req_i(bus_req),
    .bus_rsp_o(bus_rsp),
    .gpio_i(gpio_in),
    .gpio_o(gpio_out),
    .gpio_oe_o(gpio_oe),
    .exit_valid_o(exit_valid),
    .exit_value_o(exit_value),
    .cpu_powergate_switch_o(switch_out),
    .cpu_powergate_switch_ack_i(switch_ack),
    .cpu_powergate_iso_o(iso_out),
    .cpu_rst_no(cpu_rst_n),
    .irq_o(irq)
  );

  bind mcu_ao_top mcu_ao_properties u_props (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .bus_req_i(bus_req_i),
    .bus_rsp_i(bus_rsp_o),
    .switch_i(cpu_powergate_switch_o),
    .iso_i(cpu_powergate_iso_o),
    .cpu_rst_ni(cpu_rst_no)
  );

  assign out_val[OUT_EXIT_VALUE] = exit_value;
  assign out_val[OUT_EXIT_VALID] = data_t'(exit_valid);
  assign out_val[OUT_GPIO]       = data_t'(gpio_out);
  assign out_val[OUT_GPIO_OE]    = data_t'(gpio_oe);
  assign out_val[OUT_IRQ]        = irq;
  assign out_val[OUT_PWR]        = data_t'({switch_out, iso_out, cpu_rst_n});

  always #5 clk_i = ~clk_i;

  // power switch answers after a random number of cycles
  initial begin
    void'($urandom(62390));
    forever begin
      @(posedge clk_i);
      if (!rst_i && switch_out !== switch_ack) begin
        ack_delay = $urandom_range(8, 1);
        repeat (ack_delay) @(posedge clk_i);
        switch_ack <= switch_out;
      end
    end
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      stop_run($sformatf("mismatch at %0d ns: %s got 0x%08h expected 0x%08h",
                         $time, name, got, exp));
    end
  endtask

  task automatic bus_access(input logic wr, input addr_t addr, input data_t wdata,
                            output reg_rsp_t rsp);
    @(posedge clk_i);
    bus_req <= '{valid: 1'b1, write: wr, addr: addr, wdata: wdata};
    @(negedge clk_i);
    rsp = bus_rsp;
    @(posedge clk_i);
    bus_req <= '0;
  endtask

  function automatic void add_step(input op_e op, input addr_t addr, input data_t data,
                                   input data_t exp);
    steps.push_back('{op: op, addr: addr, data: data, exp: exp});
  endfunction

  function automatic void build_table();
    // reset values
    add_step(OP_OUT, OUT_EXIT_VALUE, '0, '0);
    add_step(OP_OUT, OUT_EXIT_VALID, '0, '0);
    add_step(OP_OUT, OUT_GPIO, '0, '0);
    add_step(OP_OUT, OUT_GPIO_OE, '0, '0);
    add_step(OP_OUT, OUT_IRQ, '0, '0);
    add_step(OP_OUT, OUT_PWR, '0, 32'b001);
    add_step(OP_RD, AO_CTRL_BASE + PWR_STATUS_OFS, '0, data_t'(PWR_ON));
    // exit registers and the unmapped window
    add_step(OP_WR, AO_CTRL_BASE + EXIT_VALUE_OFS, 32'h1234_5678, '0);
    add_step(OP_WR, AO_CTRL_BASE + EXIT_VALID_OFS, 32'h1, '0);
    add_step(OP_OUT, OUT_EXIT_VALUE, '0, 32'h1234_5678);
    add_step(OP_OUT, OUT_EXIT_VALID, '0, 32'h1);
    add_step(OP_RD, AO_CTRL_BASE + EXIT_VALUE_OFS, '0, 32'h1234_5678);
    add_step(OP_RD, 32'h0000_3004, '0, '0);
    // gpio pins, then rising-edge interrupts with pin 1 not enabled
    add_step(OP_WR, GPIO_BASE + GPIO_OUT_OFS, 32'ha5, '0);
    add_step(OP_WR, GPIO_BASE + GPIO_OE_OFS, 32'h0f, '0);
    add_step(OP_OUT, OUT_GPIO, '0, 32'ha5);
    add_step(OP_OUT, OUT_GPIO_OE, '0, 32'h0f);
    add_step(OP_PINS, '0, 32'h3c, '0);
    add_step(OP_WAIT, '0, 32'd2, '0);
    add_step(OP_RD, GPIO_BASE + GPIO_IN_OFS, '0, 32'h3c);
    add_step(OP_PINS, '0, 32'h00, '0);
    add_step(OP_WAIT, '0, 32'd4, '0);
    add_step(OP_RD, GPIO_BASE + GPIO_INTR_STATUS_OFS, '0, '0);
    add_step(OP_WR, GPIO_BASE + GPIO_INTR_EN_OFS, 32'h05, '0);
    add_step(OP_PINS, '0, 32'h07, '0);
    add_step(OP_WAIT, '0, 32'd4, '0);
    add_step(OP_RD, GPIO_BASE + GPIO_INTR_STATUS_OFS, '0, 32'h05);
    add_step(OP_OUT, OUT_IRQ, '0, 32'h5 << IRQ_FAST_BASE);
    add_step(OP_WR, GPIO_BASE + GPIO_INTR_STATUS_OFS, 32'h01, '0);
    add_step(OP_RD, GPIO_BASE + GPIO_INTR_STATUS_OFS, '0, 32'h04);
    add_step(OP_WR, GPIO_BASE + GPIO_INTR_STATUS_OFS, 32'h04, '0);
    add_step(OP_OUT, OUT_IRQ, '0, '0);
    // timer, compare at 100
    add_step(OP_WR, TIMER_BASE + TIMER_COUNT_OFS, 32'd0, '0);
    add_step(OP_WR, TIMER_BASE + TIMER_CMP_OFS, 32'd100, '0);
    add_step(OP_WR, TIMER_BASE + TIMER_CTRL_OFS, 32'h1, '0);
    add_step(OP_OUT, OUT_IRQ, '0, '0);
    add_step(OP_WAIT, '0, 32'd120, '0);
    add_step(OP_OUT, OUT_IRQ, '0, 32'h1 << IRQ_TIMER_BIT);
    add_step(OP_WR, TIMER_BASE + TIMER_CTRL_OFS, 32'h0, '0);
    add_step(OP_OUT, OUT_IRQ, '0, '0);
    // cpu power off and back on
    add_step(OP_WR, AO_CTRL_BASE + PWR_CTRL_OFS, 32'h1, '0);
    add_step(OP_ACK, '0, 32'h1, data_t'(PWR_OFF));
    add_step(OP_OUT, OUT_PWR, '0, 32'b110);
    add_step(OP_WR, AO_CTRL_BASE + PWR_CTRL_OFS, 32'h0, '0);
    add_step(OP_ACK, '0, 32'h0, data_t'(PWR_ON));
    add_step(OP_OUT, OUT_PWR, '0, 32'b001);
  endfunction

  initial begin
    wait (!rst_i);
    repeat (steps.size() * 20 + 200) @(posedge clk_i);
    stop_run("watchdog expired before all table steps were applied");
  end

  initial begin
    wait (u_dut.u_props.fail_seen);
    stop_run("a bound assertion on the DUT failed");
  end

  initial begin
    step_t    s;
    reg_rsp_t rsp;
    int       tries;
    build_table();
    repeat (8) @(posedge clk_i);
    rst_i <= 1'b0;
    foreach (steps[i]) begin
      s = steps[i];
      case (s.op)
        OP_WR: begin
          bus_access(1'b1, s.addr, s.data, rsp);
          check_value("bus_rsp_o.ready", data_t'(rsp.ready), 32'h1);
        end
        OP_RD: begin
          bus_access(1'b0, s.addr, '0, rsp);
          check_value("bus_rsp_o.ready", data_t'(rsp.ready), 32'h1);
          check_value("bus_rsp_o.error", data_t'(rsp.error),
                      data_t'(s.addr[13:12] == 2'd3));
          check_value("bus_rsp_o.rdata", rsp.rdata, s.exp);
        end
        OP_PINS: begin
          @(posedge clk_i);
          gpio_in <= s.data[NUM_GPIO-1:0];
        end
        OP_WAIT: repeat (s.data) @(posedge clk_i);
        OP_OUT: begin
          @(negedge clk_i);
          check_value(out_names[s.addr[2:0]], out_val[s.addr[2:0]], s.exp);
        end
        default: begin
          tries = 0;
          while (switch_ack !== s.data[0] && tries < 64) begin
            @(posedge clk_i);
            tries++;
          end
          if (switch_ack !== s.data[0]) begin
            stop_run("the power switch acknowledge never arrived");
          end
          // poll the status until the sequence settles
          tries = 0;
          rsp.rdata = ~s.exp;
          while (rsp.rdata !== s.exp && tries < 32) begin
            bus_access(1'b0, AO_CTRL_BASE + PWR_STATUS_OFS, '0, rsp);
            tries++;
          end
          check_value("PWR_STATUS", rsp.rdata, s.exp);
        end
      endcase
    end
    if (!u_dut.u_props.fail_seen) begin
      $display("All checks passed");
      $finish;
    end else begin
      stop_run("a bound assertion on the DUT failed");
    end
  end

endmodule

// File: filelist.f
design/mcu_ao_pkg.sv
design/periph_bus_demux.sv
design/ao_ctrl_regs.sv
design/cpu_power_gate_fsm.sv
design/gpio_ctrl.sv
design/compare_timer.sv
design/mcu_ao_top.sv
dv/mcu_ao_properties.sv
dv/mcu_ao_tb.sv
